// ==== verilog/id_pkg.sv ====
// ------------------------------
// shared types and encodings
// for the instruction decode stage
// ------------------------------
`default_nettype none

package id_pkg;

    // ------------------------------
    // widths that carry meaning
    typedef logic [31:0] word_t;      // data and address word
    typedef logic [4:0]  reg_addr_t;  // gpr number
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  ext_kind_t;  // immediate extension kind
    typedef logic [2:0]  br_kind_t;
    typedef logic [1:0]  dest_sel_t;
    typedef logic [1:0]  mem_op_t;
    typedef logic        wb_sel_t;

    // alu operations
    localparam alu_op_t ALU_NOP = 4'd0;
    localparam alu_op_t ALU_ADD = 4'd1;
    localparam alu_op_t ALU_SUB = 4'd2;
    localparam alu_op_t ALU_AND = 4'd3;
    localparam alu_op_t ALU_OR  = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;
    localparam alu_op_t ALU_SLL = 4'd6;
    localparam alu_op_t ALU_LUI = 4'd7;

    localparam ext_kind_t EXT_SIGN  = 2'd0;
    localparam ext_kind_t EXT_ZERO  = 2'd1;
    localparam ext_kind_t EXT_UPPER = 2'd2;  // imm in upper half

    localparam br_kind_t BR_NONE = 3'd0;
    localparam br_kind_t BR_EQ   = 3'd1;
    localparam br_kind_t BR_NE   = 3'd2;
    localparam br_kind_t BR_J    = 3'd3;
    localparam br_kind_t BR_JR   = 3'd4;

    localparam dest_sel_t DEST_NONE = 2'd0;
    localparam dest_sel_t DEST_RT   = 2'd1;
    localparam dest_sel_t DEST_RD   = 2'd2;
    localparam dest_sel_t DEST_RA   = 2'd3;  // link register 31

    localparam mem_op_t MEM_NONE  = 2'd0;
    localparam mem_op_t MEM_LOAD  = 2'd1;
    localparam mem_op_t MEM_STORE = 2'd2;

    localparam wb_sel_t WB_ALU = 1'b0;
    localparam wb_sel_t WB_MEM = 1'b1;

    // ------------------------------
    // opcode field, bits 31..26
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of special, bits 5..0
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

`default_nettype wire

// ==== verilog/id_ctrl_if.sv ====
// ------------------------------
// decoded control bundle
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface id_ctrl_if;
    import id_pkg::*;

    alu_op_t     alu_op;
    logic        src_a_sa;   // operand a from shift amount
    logic        src_b_imm;  // operand b from extended imm
    ext_kind_t   ext_kind;
    dest_sel_t   dest_sel;
    mem_op_t     mem_op;
    wb_sel_t     wb_sel;
    br_kind_t    br_kind;
    logic [15:0] imm;        // raw immediate / branch offset
    logic [4:0]  sa;         // shift amount

    // decoder drives the whole bundle
    modport dec (
        output alu_op, src_a_sa, src_b_imm, ext_kind, dest_sel,
               mem_op, wb_sel, br_kind, imm, sa
    );

    modport stage (
        input alu_op, src_a_sa, src_b_imm, ext_kind, dest_sel,
              mem_op, wb_sel, imm, sa
    );

    modport branch (input br_kind, imm);

endinterface

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
// ------------------------------
// instruction decoder
// splits the word into fields and produces control codes
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  id_pkg::word_t     instr,
    output id_pkg::reg_addr_t rs,
    output id_pkg::reg_addr_t rt,
    output id_pkg::reg_addr_t rd,
    output logic [25:0]       instr_index,
    id_ctrl_if.dec            ctrl
);
    import id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    // ------------------------------
    // field extraction
    assign opcode      = instr[31:26];
    assign funct       = instr[5:0];
    assign rs          = instr[25:21];
    assign rt          = instr[20:16];
    assign rd          = instr[15:11];
    assign instr_index = instr[25:0];  // j / jal index
    assign ctrl.imm    = instr[15:0];
    assign ctrl.sa     = instr[10:6];

    // ------------------------------
    // control decode
    always_comb begin
        // defaults give a nop
        ctrl.alu_op    = ALU_NOP;
        ctrl.src_a_sa  = 1'b0;
        ctrl.src_b_imm = 1'b0;
        ctrl.ext_kind  = EXT_SIGN;
        ctrl.dest_sel  = DEST_NONE;
        ctrl.mem_op    = MEM_NONE;
        ctrl.wb_sel    = WB_ALU;
        ctrl.br_kind   = BR_NONE;

        case (opcode)
            OP_SPECIAL: begin
                ctrl.dest_sel = DEST_RD;  // r-type result into rd
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl.alu_op   = ALU_SLL;
                        ctrl.src_a_sa = 1'b1;  // shift rt by sa
                    end
                    FN_JR: begin
                        ctrl.dest_sel = DEST_NONE;
                        ctrl.br_kind  = BR_JR;
                    end
                    default: ctrl.dest_sel = DEST_NONE;  // unknown funct
                endcase
            end
            OP_ADDIU: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.src_b_imm = 1'b1;
                ctrl.dest_sel  = DEST_RT;
            end
            OP_ORI: begin
                ctrl.alu_op    = ALU_OR;
                ctrl.src_b_imm = 1'b1;
                ctrl.ext_kind  = EXT_ZERO;
                ctrl.dest_sel  = DEST_RT;
            end
            OP_LUI: begin
                ctrl.alu_op    = ALU_LUI;
                ctrl.src_b_imm = 1'b1;
                ctrl.ext_kind  = EXT_UPPER;
                ctrl.dest_sel  = DEST_RT;
            end
            OP_LW: begin
                ctrl.alu_op    = ALU_ADD;  // base + offset
                ctrl.src_b_imm = 1'b1;
                ctrl.dest_sel  = DEST_RT;
                ctrl.mem_op    = MEM_LOAD;
                ctrl.wb_sel    = WB_MEM;
            end
            OP_SW: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_op    = MEM_STORE;  // no gpr write
            end
            OP_BEQ: ctrl.br_kind = BR_EQ;
            OP_BNE: ctrl.br_kind = BR_NE;
            OP_J:   ctrl.br_kind = BR_J;
            OP_JAL: begin
                ctrl.br_kind  = BR_J;
                ctrl.alu_op   = ALU_ADD;  // link addr + 0
                ctrl.dest_sel = DEST_RA;
            end
            default: ;  // unsupported opcode stays a nop
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// ------------------------------
// gpr file with two reads and one write
// register 0 always reads zero
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int REG_ADDR_W = 5
) (
    input  logic              clk,
    input  logic              rst_n,
    input  id_pkg::reg_addr_t rs,
    input  id_pkg::reg_addr_t rt,
    output id_pkg::word_t     rs_data,
    output id_pkg::word_t     rt_data,
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_addr,
    input  id_pkg::word_t     wb_data
);
    import id_pkg::*;

    localparam int DEPTH = 2 ** REG_ADDR_W;

    word_t regs [DEPTH];  // register array

    // write port clears whole file on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_addr[REG_ADDR_W-1:0] != '0)) begin  // r0 never written
            regs[wb_addr[REG_ADDR_W-1:0]] <= wb_data;
        end
    end

    // combinational reads without bypass
    assign rs_data = regs[rs[REG_ADDR_W-1:0]];
    assign rt_data = regs[rt[REG_ADDR_W-1:0]];

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
// ------------------------------
// branch condition and target
// resolved in the decode cycle
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  id_pkg::word_t npc,
    input  id_pkg::word_t rs_data,
    input  id_pkg::word_t rt_data,
    input  logic [25:0]   instr_index,
    id_ctrl_if.branch     ctrl,
    output logic          br_taken,
    output id_pkg::word_t br_target
);
    import id_pkg::*;

    word_t br_offset;  // sign-extended offset, word aligned
    word_t br_dest;
    word_t jump_dest;
    logic  rs_eq_rt;

    // ------------------------------
    // condition and candidate targets
    assign rs_eq_rt  = (rs_data == rt_data);
    assign br_offset = {{14{ctrl.imm[15]}}, ctrl.imm, 2'b00};
    assign br_dest   = npc + br_offset;                       // pc-relative
    assign jump_dest = {npc[31:28], instr_index, 2'b00};      // region jump

    // select by branch kind
    always_comb begin
        case (ctrl.br_kind)
            BR_EQ: begin
                br_taken  = rs_eq_rt;
                br_target = br_dest;
            end
            BR_NE: begin
                br_taken  = !rs_eq_rt;
                br_target = br_dest;
            end
            BR_J: begin
                br_taken  = 1'b1;  // j and jal
                br_target = jump_dest;
            end
            BR_JR: begin
                br_taken  = 1'b1;
                br_target = rs_data;  // register target
            end
            default: begin
                br_taken  = 1'b0;
                br_target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/id_stage_reg.sv ====
// ------------------------------
// operand select and id/ex register
// advances only on go_id
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module id_stage_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              go_id,
    input  id_pkg::word_t     npc,
    input  id_pkg::word_t     pc,
    input  id_pkg::word_t     rs_data,
    input  id_pkg::word_t     rt_data,
    input  id_pkg::reg_addr_t rt,
    input  id_pkg::reg_addr_t rd,
    id_ctrl_if.stage          ctrl,
    output id_pkg::alu_op_t   id_alu_op,
    output id_pkg::word_t     id_src_a,
    output id_pkg::word_t     id_src_b,
    output id_pkg::word_t     id_store_data,
    output id_pkg::reg_addr_t id_dest,
    output logic              id_reg_we,
    output id_pkg::mem_op_t   id_mem_op,
    output id_pkg::wb_sel_t   id_wb_sel,
    output id_pkg::word_t     id_pc
);
    import id_pkg::*;

    word_t     ext_imm;
    word_t     src_a;
    word_t     src_b;
    word_t     link_addr;  // return address for jal
    reg_addr_t dest;
    logic      is_link;

    assign is_link   = (ctrl.dest_sel == DEST_RA);
    assign link_addr = npc + 32'd4;

    // ------------------------------
    // immediate extension
    always_comb begin
        case (ctrl.ext_kind)
            EXT_SIGN:  ext_imm = {{16{ctrl.imm[15]}}, ctrl.imm};
            EXT_ZERO:  ext_imm = {16'h0000, ctrl.imm};
            EXT_UPPER: ext_imm = {ctrl.imm, 16'h0000};  // lui
            default:   ext_imm = '0;
        endcase
    end

    // operand a then operand b
    assign src_a = ctrl.src_a_sa ? {27'd0, ctrl.sa} :
                   is_link       ? link_addr : rs_data;
    assign src_b = ctrl.src_b_imm ? ext_imm :
                   is_link        ? '0 : rt_data;

    // destination number
    always_comb begin
        case (ctrl.dest_sel)
            DEST_RT: dest = rt;
            DEST_RD: dest = rd;
            DEST_RA: dest = 5'd31;
            default: dest = '0;
        endcase
    end

    // ------------------------------
    // id/ex stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_alu_op     <= ALU_NOP;
            id_src_a      <= '0;
            id_src_b      <= '0;
            id_store_data <= '0;
            id_dest       <= '0;
            id_reg_we     <= 1'b0;
            id_mem_op     <= MEM_NONE;
            id_wb_sel     <= WB_ALU;
            id_pc         <= '0;
        end else if (go_id) begin  // low holds the stage
            id_alu_op     <= ctrl.alu_op;
            id_src_a      <= src_a;
            id_src_b      <= src_b;
            id_store_data <= rt_data;  // sw data
            id_dest       <= dest;
            id_reg_we     <= (ctrl.dest_sel != DEST_NONE);
            id_mem_op     <= ctrl.mem_op;
            id_wb_sel     <= ctrl.wb_sel;
            id_pc         <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/id_top.sv ====
// ------------------------------
// instruction decode stage top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module id_top #(
    parameter int REG_ADDR_W = 5
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              go_id,
    input  id_pkg::word_t     instr,
    input  id_pkg::word_t     pc,
    input  id_pkg::word_t     npc,
    // writeback port from a later stage
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_addr,
    input  id_pkg::word_t     wb_data,
    // id/ex outputs
    output id_pkg::alu_op_t   id_alu_op,
    output id_pkg::word_t     id_src_a,
    output id_pkg::word_t     id_src_b,
    output id_pkg::word_t     id_store_data,
    output id_pkg::reg_addr_t id_dest,
    output logic              id_reg_we,
    output id_pkg::mem_op_t   id_mem_op,
    output id_pkg::wb_sel_t   id_wb_sel,
    output id_pkg::word_t     id_pc,
    // same-cycle branch result
    output logic              br_taken,
    output id_pkg::word_t     br_target
);
    import id_pkg::*;

    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [25:0] instr_index;
    word_t       rs_data;
    word_t       rt_data;

    id_ctrl_if ctrl_if ();  // decoded controls

    instr_decoder u_decoder (
        .instr       (instr),
        .rs          (rs),
        .rt          (rt),
        .rd          (rd),
        .instr_index (instr_index),
        .ctrl        (ctrl_if.dec)
    );

    reg_file #(
        .REG_ADDR_W (REG_ADDR_W)
    ) u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (rs),
        .rt      (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    branch_unit u_branch (
        .npc         (npc),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .instr_index (instr_index),
        .ctrl        (ctrl_if.branch),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

    id_stage_reg u_stage_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .go_id         (go_id),
        .npc           (npc),
        .pc            (pc),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .rt            (rt),
        .rd            (rd),
        .ctrl          (ctrl_if.stage),
        .id_alu_op     (id_alu_op),
        .id_src_a      (id_src_a),
        .id_src_b      (id_src_b),
        .id_store_data (id_store_data),
        .id_dest       (id_dest),
        .id_reg_we     (id_reg_we),
        .id_mem_op     (id_mem_op),
        .id_wb_sel     (id_wb_sel),
        .id_pc         (id_pc)
    );

endmodule

`default_nettype wire

// ==== tb/tb_id_top.sv ====
// ------------------------------
// testbench for the decode stage
// replays the pattern file against id_top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_id_top;
    import id_pkg::*;

    localparam string PATTERN_FILE = "tb/id_patterns.txt";

    // dut ports
    logic      clk;
    logic      rst_n;
    logic      go_id;
    word_t     instr;
    word_t     pc;
    word_t     npc;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    alu_op_t   id_alu_op;
    word_t     id_src_a;
    word_t     id_src_b;
    word_t     id_store_data;
    reg_addr_t id_dest;
    logic      id_reg_we;
    mem_op_t   id_mem_op;
    wb_sel_t   id_wb_sel;
    word_t     id_pc;
    logic      br_taken;
    word_t     br_target;

    // fields of the current pattern line
    string     lines [$];
    string     cur_name;
    word_t     p_instr, p_pc, p_npc, p_wdata;
    reg_addr_t p_waddr;
    logic      p_go;
    logic      e_taken, e_we, e_wb;
    word_t     e_target, e_src_a, e_src_b, e_store, e_pc;
    alu_op_t   e_alu;
    reg_addr_t e_dest;
    mem_op_t   e_mem;

    int   pass_cnt;
    int   fail_cnt;
    int   test_errs;  // mismatches in current test
    logic loaded;
    logic load_err;

    id_top #(.REG_ADDR_W(5)) UUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    // ------------------------------
    // compare tasks, one per result type
    task automatic check_word(input string what, input word_t exp_v, input word_t act_v);
        if (act_v !== exp_v) begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_name, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_reg_addr(input string what, input reg_addr_t exp_v,
                                  input reg_addr_t act_v);
        if (act_v !== exp_v) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", cur_name, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_alu_op(input alu_op_t exp_v, input alu_op_t act_v);
        if (act_v !== exp_v) begin
            $display("[ERROR] %s id_alu_op: expected %0d, actual %0d", cur_name, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_mem_op(input mem_op_t exp_v, input mem_op_t act_v);
        if (act_v !== exp_v) begin
            $display("[ERROR] %s id_mem_op: expected %0d, actual %0d", cur_name, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("[ERROR] %s %s: expected %b, actual %b", cur_name, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    // ------------------------------
    // keep data lines, drop comments and blanks
    task automatic load_patterns();
        int    fd;
        string text;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PATTERN_FILE);
            load_err = 1'b1;
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (text.len() > 1 && text.substr(0, 0) != "#") begin
                    lines.push_back(text);
                end
            end
            $fclose(fd);
        end
    endtask

    // one pattern line, entered and left at posedge + 5 ns
    task automatic run_line(input int idx, input string text);
        int n;
        test_errs = 0;
        n = 0;
        if (text.substr(0, 0) == "W") begin
            n = $sscanf(text, "W %s %h %h", cur_name, p_waddr, p_wdata);
        end else if (text.substr(0, 0) == "I") begin
            n = $sscanf(text, "I %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        cur_name, p_instr, p_pc, p_npc, p_go, e_taken, e_target,
                        e_alu, e_src_a, e_src_b, e_store, e_dest, e_we, e_mem, e_wb, e_pc);
        end

        if (text.substr(0, 0) == "W" && n == 3) begin
            wb_we   = 1'b1;  // register write, stage held
            wb_addr = p_waddr;
            wb_data = p_wdata;
            go_id   = 1'b0;
            @(posedge clk);
            #5;
        end else if (text.substr(0, 0) == "I" && n == 16) begin
            wb_we = 1'b0;
            instr = p_instr;
            pc    = p_pc;
            npc   = p_npc;
            go_id = p_go;
            @(negedge clk);  // branch result settles in the same cycle
            check_bit("br_taken", e_taken, br_taken);
            check_word("br_target", e_target, br_target);
            @(posedge clk);
            #1;
            check_alu_op(e_alu, id_alu_op);
            check_word("id_src_a", e_src_a, id_src_a);
            check_word("id_src_b", e_src_b, id_src_b);
            check_word("id_store_data", e_store, id_store_data);
            check_reg_addr("id_dest", e_dest, id_dest);
            check_bit("id_reg_we", e_we, id_reg_we);
            check_mem_op(e_mem, id_mem_op);
            check_bit("id_wb_sel", e_wb, id_wb_sel);
            check_word("id_pc", e_pc, id_pc);
            #4;
        end else begin
            $display("pattern line %0d is malformed and was skipped", idx + 1);
            test_errs++;
            cur_name = "malformed";
        end

        if (test_errs == 0) begin
            pass_cnt++;
            $display("[PASS] %s", cur_name);
        end else begin
            fail_cnt++;
            $display("[FAIL] %s", cur_name);
        end
    endtask

    // ------------------------------
    // main sequence
    initial begin
        rst_n    = 1'b0;
        go_id    = 1'b0;
        instr    = '0;
        pc       = '0;
        npc      = '0;
        wb_we    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        loaded   = 1'b0;
        load_err = 1'b0;

        load_patterns();
        loaded = 1'b1;

        repeat (2) @(posedge clk);  // two reset cycles
        #5 rst_n = 1'b1;

        foreach (lines[i]) begin
            run_line(i, lines[i]);
        end

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !load_err && pass_cnt > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, three cycles per line plus margin
    initial begin
        wait (loaded);
        #((lines.size() + 10) * 300);
        $display("watchdog expired before all pattern lines were applied");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/id_pkg.sv
verilog/id_ctrl_if.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/branch_unit.sv
verilog/id_stage_reg.sv
verilog/id_top.sv
tb/tb_id_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the decode stage testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_id_top -f files.f -o tb_id_top_sim

out=$(./obj_dir/tb_id_top_sim)
echo "$out"

if echo "$out" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

// ==== tb/id_patterns.txt ====
# W name reg data   (one writeback cycle, go_id low)
# I name instr pc npc go | taken target | alu src_a src_b store dest we mem wb pc
I reset_hold 00000000 00400000 00400004 0 0 00000000 0 00000000 00000000 00000000 00 0 0 0 00000000
I addu_zero 00222821 00400004 00400008 1 0 00000000 1 00000000 00000000 00000000 05 1 0 0 00400004
W w_r1 01 00001234
W w_r2 02 00000010
W w_r3 03 fffffff0
W w_r0 00 deadbeef
W w_r4 04 00000010
W w_r8 08 00400100
I addu 00222821 00400008 0040000c 1 0 00000000 1 00001234 00000010 00000010 05 1 0 0 00400008
I subu 00613023 0040000c 00400010 1 0 00000000 2 fffffff0 00001234 00001234 06 1 0 0 0040000c
I and 00233824 00400010 00400014 1 0 00000000 3 00001234 fffffff0 fffffff0 07 1 0 0 00400010
I or_r0 00404825 00400014 00400018 1 0 00000000 4 00000010 00000000 00000000 09 1 0 0 00400014
I slt 0062502a 00400018 0040001c 1 0 00000000 5 fffffff0 00000010 00000010 0a 1 0 0 00400018
I sll 00015900 0040001c 00400020 1 0 00000000 6 00000004 00001234 00001234 0b 1 0 0 0040001c
I addiu_neg 242cfff8 00400020 00400024 1 0 00000000 1 00001234 fffffff8 00000000 0c 1 0 0 00400020
I lw_neg 8c4dfffc 00400024 00400028 1 0 00000000 1 00000010 fffffffc 00000000 0d 1 1 1 00400024
I ori_zext 342e8001 00400028 0040002c 1 0 00000000 4 00001234 00008001 00000000 0e 1 0 0 00400028
I lui 3c0f8765 0040002c 00400030 1 0 00000000 7 00000000 87650000 00000000 0f 1 0 0 0040002c
I sw ac230008 00400030 00400034 1 0 00000000 1 00001234 00000008 fffffff0 00 0 2 0 00400030
I beq_taken_fwd 10440003 00400034 00400038 1 1 00400044 0 00000010 00000010 00000010 00 0 0 0 00400034
I beq_ntaken_back 1022fffc 00400038 0040003c 1 0 0040002c 0 00001234 00000010 00000010 00 0 0 0 00400038
I bne_taken_back 1422fffe 0040003c 00400040 1 1 00400038 0 00001234 00000010 00000010 00 0 0 0 0040003c
I bne_ntaken_fwd 14440010 00400040 00400044 1 0 00400084 0 00000010 00000010 00000010 00 0 0 0 00400040
I j 08123456 30000000 30000004 1 1 3048d158 0 00000000 00000000 00000000 00 0 0 0 30000000
I jr 01000008 00400048 0040004c 1 1 00400100 0 00400100 00000000 00000000 00 0 0 0 00400048
I jal 0c100020 90000010 90000014 1 1 90400080 1 90000018 00000000 00000000 1f 1 0 0 90000010
I hold_go0 14220001 00400060 00400064 0 1 00400068 1 90000018 00000000 00000000 1f 1 0 0 90000010
I unknown_op fc000000 00400064 00400068 1 0 00000000 0 00000000 00000000 00000000 00 0 0 0 00400064
